//--- src/motion_pkg.sv
package motion_pkg;

  typedef logic [63:0] word_t;          // One SPI word
  typedef logic [63:0] tick_t;          // Move duration in DDA ticks
  typedef logic signed [63:0] rate_t;   // Increment and increment-of-increment
  typedef logic signed [63:0] count_t;  // Encoder position
  typedef logic [7:0] div_t;
  typedef logic [7:0] current_t;
  typedef logic [2:0] msteps_t;         // Log2 of microsteps per full step

  // Header codes in the top byte of the first word of a message
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'd1,
    CMD_MOTOR_ENABLE     = 8'd10,
    CMD_MOTORCONFIG      = 8'd16,
    CMD_CLK_DIVISOR      = 8'd26,
    CMD_API_VERSION      = 8'd254
  } cmd_e;

  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd3;

  // Which word of a message comes next
  typedef enum logic [2:0] {
    HEADER,
    DURATION,
    INCREMENT,
    INCINC,
    VERSION_WAIT
  } dec_state_e;

  typedef enum logic {
    IDLE,
    RUN
  } step_state_e;

endpackage

//--- src/move_if.sv
interface move_if;
  import motion_pkg::*;

  tick_t duration;
  rate_t increment;
  rate_t incinc;
  logic  dir;
  logic  valid;  // Buffer holds at least one move
  logic  take;   // Stepper pops the head entry

  modport source (
    output duration, increment, incinc, dir, valid,
    input  take
  );

  modport sink (
    input  duration, increment, incinc, dir, valid,
    output take
  );
endinterface

//--- src/spi_word.sv
module spi_word (
  input  logic              CLK,
  input  logic              reset,
  input  logic              SCK,
  input  logic              CS,
  input  logic              COPI,
  input  motion_pkg::word_t tx_word,
  output logic              CIPO,
  output motion_pkg::word_t rx_word,
  output logic              rx_valid
);
  import motion_pkg::*;

  word_t      rx_shift;
  word_t      tx_hold;
  logic [5:0] tx_bit;
  logic [2:0] cs_sync;  // Two sync stages plus previous value
  logic       cs_rise;

  // SCK domain receive with MSB first
  always_ff @(posedge SCK) begin
    if (!CS) begin
      rx_shift <= {rx_shift[62:0], COPI};
    end
  end

  // Reply word is frozen for the whole transfer
  always_ff @(negedge CS) begin
    tx_hold <= tx_word;
  end

  // Bit index advances on falling edges and sits at the MSB while deselected
  always_ff @(negedge SCK or posedge CS) begin
    if (CS) begin
      tx_bit <= '0;
    end else begin
      tx_bit <= tx_bit + 6'd1;
    end
  end

  assign CIPO = !CS && tx_hold[~tx_bit];  // ~tx_bit is 63 - tx_bit

  // CLK domain side
  assign cs_rise = cs_sync[1] && !cs_sync[2];

  always_ff @(posedge CLK) begin
    if (reset) begin
      cs_sync  <= '1;  // Deselected
      rx_valid <= 1'b0;
    end else begin
      cs_sync  <= {cs_sync[1:0], CS};
      rx_valid <= cs_rise;
    end
  end

  // rx_shift is quiet while CS is high so it can be sampled here
  always_ff @(posedge CLK) begin
    if (cs_rise) begin
      rx_word <= rx_shift;
    end
  end

  // Words are at least 64 SCK periods apart and SCK is slower than CLK
  a_single_pulse: assert property (@(posedge CLK) disable iff (reset)
    rx_valid |=> (!rx_valid) [*63]);

endmodule

//--- src/cmd_decoder.sv
module cmd_decoder (
  input  logic                 CLK,
  input  logic                 reset,
  input  motion_pkg::word_t    rx_word,
  input  logic                 rx_valid,
  input  motion_pkg::count_t   enc_count,
  input  logic                 mv_ready,
  input  logic                 buf_full,
  output motion_pkg::word_t    tx_word,
  output motion_pkg::tick_t    mv_duration,
  output motion_pkg::rate_t    mv_increment,
  output motion_pkg::rate_t    mv_incinc,
  output logic                 mv_dir,
  output logic                 mv_valid,
  output logic                 enable,
  output motion_pkg::div_t     clk_div,
  output motion_pkg::current_t current,
  output motion_pkg::msteps_t  msteps,
  output logic                 buffer_dtr
);
  import motion_pkg::*;

  dec_state_e state;
  count_t     enc_snap;  // Encoder position at move header
  logic [7:0] header;

  assign header     = rx_word[63:56];
  assign buffer_dtr = !buf_full;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= HEADER;
      tx_word  <= '0;
      mv_valid <= 1'b0;
      enable   <= 1'b0;
      clk_div  <= 8'd40;
      current  <= 8'd140;
      msteps   <= 3'd1;
    end else begin
      if (mv_valid && mv_ready) mv_valid <= 1'b0;
      if (rx_valid) begin
        tx_word <= '0;  // Reply only lives for one transfer
        case (state)
          HEADER: begin
            case (header)
              CMD_COORDINATED_STEP: state <= DURATION;
              CMD_MOTOR_ENABLE:     enable <= rx_word[0];
              CMD_MOTORCONFIG: begin
                current <= rx_word[15:8];
                msteps  <= rx_word[2:0];
              end
              CMD_CLK_DIVISOR:      clk_div <= rx_word[7:0];
              CMD_API_VERSION: begin
                tx_word <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
                state   <= VERSION_WAIT;
              end
              default: ;  // Unknown headers are dropped
            endcase
          end
          DURATION:  state <= INCREMENT;
          INCREMENT: begin
            tx_word <= enc_snap;  // Host reads it during the incinc word
            state   <= INCINC;
          end
          INCINC: begin
            mv_valid <= 1'b1;
            state    <= HEADER;
          end
          default: state <= HEADER;  // VERSION_WAIT swallows the dummy word
        endcase
      end
    end
  end

  // Move fields. The host waits on BUFFER_DTR so a pending move is not overwritten
  always_ff @(posedge CLK) begin
    if (rx_valid) begin
      case (state)
        HEADER: begin
          if (header == CMD_COORDINATED_STEP) begin
            mv_dir   <= rx_word[0];
            enc_snap <= enc_count;
          end
        end
        DURATION:  mv_duration <= rx_word;
        INCREMENT: mv_increment <= rx_word;
        INCINC:    mv_incinc <= rx_word;
        default: ;
      endcase
    end
  end

  a_valid_held: assert property (@(posedge CLK) disable iff (reset)
    mv_valid && !mv_ready |=> mv_valid && $stable(mv_duration) &&
      $stable(mv_increment) && $stable(mv_incinc) && $stable(mv_dir));

endmodule

//--- src/move_buffer.sv
module move_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  logic              CLK,
  input  logic              reset,
  input  logic              halt,
  input  motion_pkg::tick_t wr_duration,
  input  motion_pkg::rate_t wr_increment,
  input  motion_pkg::rate_t wr_incinc,
  input  logic              wr_dir,
  input  logic              wr_valid,
  output logic              wr_ready,
  output logic              full,
  move_if.source            mv
);
  import motion_pkg::*;

  localparam int PTR_W = $clog2(BUF_DEPTH);

  tick_t dur_mem    [BUF_DEPTH];
  rate_t inc_mem    [BUF_DEPTH];
  rate_t incinc_mem [BUF_DEPTH];
  logic  dir_mem    [BUF_DEPTH];

  logic [PTR_W:0] wr_ptr;  // MSB is the wrap bit
  logic [PTR_W:0] rd_ptr;
  logic           push;
  logic           pop;

  assign full     = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                    (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign wr_ready = !full && !halt;
  assign push     = wr_valid && wr_ready;
  assign pop      = mv.take && mv.valid;

  assign mv.valid     = wr_ptr != rd_ptr;
  assign mv.duration  = dur_mem[rd_ptr[PTR_W-1:0]];
  assign mv.increment = inc_mem[rd_ptr[PTR_W-1:0]];
  assign mv.incinc    = incinc_mem[rd_ptr[PTR_W-1:0]];
  assign mv.dir       = dir_mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (halt) rd_ptr <= wr_ptr;  // Flush everything queued
      else if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      dur_mem[wr_ptr[PTR_W-1:0]]    <= wr_duration;
      inc_mem[wr_ptr[PTR_W-1:0]]    <= wr_increment;
      incinc_mem[wr_ptr[PTR_W-1:0]] <= wr_incinc;
      dir_mem[wr_ptr[PTR_W-1:0]]    <= wr_dir;
    end
  end

  // Occupancy never goes past the depth
  a_no_write_full: assert property (@(posedge CLK) disable iff (reset)
    (PTR_W + 1)'(wr_ptr - rd_ptr) <= BUF_DEPTH);

endmodule

//--- src/dda_stepper.sv
module dda_stepper #(
  parameter int DDA_FRAC = 32
) (
  input  logic             CLK,
  input  logic             reset,
  input  logic             halt,
  input  motion_pkg::div_t clk_div,
  output logic             step,
  output logic             dir,
  output logic             move_done,
  move_if.sink             mv
);
  import motion_pkg::*;

  localparam rate_t STEP_ONE = rate_t'(64'd1 << DDA_FRAC);  // One full step

  step_state_e state;
  div_t        div_cnt;
  tick_t       tick_cnt;  // Ticks left after the current one
  rate_t       rate;
  rate_t       incinc;
  rate_t       acc;
  rate_t       acc_next;
  logic        tick;

  assign mv.take  = (state == IDLE) && mv.valid && !halt;
  assign tick     = (state == RUN) && (div_cnt == '0);
  assign acc_next = acc + rate;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state     <= IDLE;
      step      <= 1'b0;
      move_done <= 1'b0;
    end else begin
      step <= 1'b0;
      if (halt) begin
        state <= IDLE;
      end else if (mv.take) begin
        state <= RUN;
      end else if (tick) begin
        step <= acc_next >= STEP_ONE;
        if (tick_cnt == '0) begin  // Last tick of the move
          state     <= IDLE;
          move_done <= !move_done;
        end
      end
    end
  end

  // Per-move datapath with a fresh accumulator for every move
  always_ff @(posedge CLK) begin
    if (mv.take) begin
      dir      <= mv.dir;
      tick_cnt <= mv.duration;
      rate     <= mv.increment;
      incinc   <= mv.incinc;
      acc      <= '0;
      div_cnt  <= clk_div;
    end else if (state == RUN) begin
      if (tick) begin
        div_cnt  <= clk_div;
        tick_cnt <= tick_cnt - 1'b1;
        rate     <= rate + incinc;
        if (acc_next >= STEP_ONE) acc <= acc_next - STEP_ONE;
        else acc <= acc_next;
      end else begin
        div_cnt <= div_cnt - 1'b1;
      end
    end
  end

endmodule

//--- src/hbridge_driver.sv
module hbridge_driver (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 step,
  input  logic                 dir,
  input  logic                 enable,
  input  motion_pkg::msteps_t  msteps,
  input  motion_pkg::current_t current,
  output logic                 phase_a1,
  output logic                 phase_a2,
  output logic                 phase_b1,
  output logic                 phase_b2,
  output logic                 vref_a,
  output logic                 vref_b
);
  import motion_pkg::*;

  logic [31:0] position;  // Microstep position that wraps freely
  logic [31:0] full_pos;
  logic [3:0]  pattern;   // {a1, a2, b1, b2}
  current_t    pwm_cnt;

  always_ff @(posedge CLK) begin
    if (reset) begin
      position <= '0;
      pwm_cnt  <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (step) position <= dir ? position + 1'b1 : position - 1'b1;
    end
  end

  assign full_pos = position >> msteps;

  always_comb begin
    case (full_pos[1:0])
      2'd0:    pattern = 4'b1010;
      2'd1:    pattern = 4'b0110;
      2'd2:    pattern = 4'b0101;
      default: pattern = 4'b1001;
    endcase
  end

  assign {phase_a1, phase_a2, phase_b1, phase_b2} = enable ? pattern : 4'b0000;

  // Same current reference on both coils
  assign vref_a = pwm_cnt < current;
  assign vref_b = pwm_cnt < current;

endmodule

//--- src/quad_enc.sv
module quad_enc (
  input  logic               CLK,
  input  logic               reset,
  input  logic               enc_a,
  input  logic               enc_b,
  output motion_pkg::count_t count,
  output logic               fault
);
  import motion_pkg::*;

  logic [2:0] a_sync;  // Two sync stages plus previous value
  logic [2:0] b_sync;
  logic       a_chg;
  logic       b_chg;
  logic       up;

  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[1:0], enc_a};
    b_sync <= {b_sync[1:0], enc_b};
  end

  assign a_chg = a_sync[2] ^ a_sync[1];
  assign b_chg = b_sync[2] ^ b_sync[1];
  assign up    = a_sync[1] ^ b_sync[2];  // A leading B counts up

  always_ff @(posedge CLK) begin
    if (reset) begin
      count <= '0;
      fault <= 1'b0;
    end else if (a_chg && b_chg) begin
      fault <= 1'b1;  // Lost an edge and stays set until reset
    end else if (a_chg || b_chg) begin
      count <= up ? count + 1'b1 : count - 1'b1;
    end
  end

endmodule

//--- src/motion_top.sv
module motion_top #(
  parameter int BUF_DEPTH = 4,
  parameter int DDA_FRAC  = 32
) (
  input  logic CLK,
  input  logic reset,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  input  logic ENC_A,
  input  logic ENC_B,
  input  logic HALT,
  output logic CIPO,
  output logic PHASE_A1,
  output logic PHASE_A2,
  output logic PHASE_B1,
  output logic PHASE_B2,
  output logic VREF_A,
  output logic VREF_B,
  output logic BUFFER_DTR,
  output logic MOVE_DONE,
  output logic ENC_FAULT
);
  import motion_pkg::*;

  word_t    rx_word;
  word_t    tx_word;
  logic     rx_valid;
  count_t   enc_count;
  tick_t    mv_duration;
  rate_t    mv_increment;
  rate_t    mv_incinc;
  logic     mv_dir;
  logic     mv_valid;
  logic     mv_ready;
  logic     buf_full;
  logic     enable;
  logic     step;
  logic     dir;
  div_t     clk_div;
  current_t current;
  msteps_t  msteps;

  move_if u_move ();

  spi_word u_spi (
    .CLK, .reset, .SCK, .CS, .COPI, .tx_word, .CIPO, .rx_word, .rx_valid
  );

  cmd_decoder u_dec (
    .CLK, .reset, .rx_word, .rx_valid, .enc_count, .mv_ready, .buf_full,
    .tx_word, .mv_duration, .mv_increment, .mv_incinc, .mv_dir, .mv_valid,
    .enable, .clk_div, .current, .msteps, .buffer_dtr(BUFFER_DTR)
  );

  move_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
    .CLK, .reset, .halt(HALT),
    .wr_duration(mv_duration), .wr_increment(mv_increment), .wr_incinc(mv_incinc),
    .wr_dir(mv_dir), .wr_valid(mv_valid), .wr_ready(mv_ready), .full(buf_full),
    .mv(u_move.source)
  );

  dda_stepper #(.DDA_FRAC(DDA_FRAC)) u_dda (
    .CLK, .reset, .halt(HALT), .clk_div, .step, .dir, .move_done(MOVE_DONE),
    .mv(u_move.sink)
  );

  hbridge_driver u_hb (
    .CLK, .reset, .step, .dir, .enable, .msteps, .current,
    .phase_a1(PHASE_A1), .phase_a2(PHASE_A2), .phase_b1(PHASE_B1),
    .phase_b2(PHASE_B2), .vref_a(VREF_A), .vref_b(VREF_B)
  );

  quad_enc u_enc (
    .CLK, .reset, .enc_a(ENC_A), .enc_b(ENC_B), .count(enc_count), .fault(ENC_FAULT)
  );

endmodule

//--- verif/tb_motion_top.sv
module tb_motion_top;
  import motion_pkg::*;

  localparam int    BUF_DEPTH   = 4;
  localparam int    DDA_FRAC    = 32;
  localparam int    NUM_MOVES   = 6;
  localparam int    DIVISOR     = 3;
  localparam int    LONG_DUR    = 10000;
  localparam int    WORD_CYCLES = 64 * 8 + 16;  // SCK bits plus CS gap
  localparam rate_t STEP_ONE    = rate_t'(64'd1 << DDA_FRAC);

  logic CLK;
  logic reset;
  logic SCK, CS, COPI;
  logic ENC_A, ENC_B, HALT;
  logic CIPO, BUFFER_DTR, MOVE_DONE, ENC_FAULT;
  logic PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2;
  logic VREF_A, VREF_B;

  logic [31:0] lcg_state  = 32'h8a0b_1baf;
  logic        fail_seen  = 1'b0;
  logic        reset_done = 1'b0;
  int          cycle_limit = 0;
  count_t      enc_model  = '0;   // Expected encoder count
  logic [1:0]  enc_phase  = 2'd0;
  logic [31:0] net_pos    = '0;   // Expected microstep position
  msteps_t     cur_msteps = 3'd1;
  int          expect_q[$];       // Signed step count per queued move

  tick_t mv_dur    [NUM_MOVES];
  rate_t mv_inc    [NUM_MOVES];
  rate_t mv_incinc [NUM_MOVES];
  logic  mv_dir    [NUM_MOVES];

  motion_top #(.BUF_DEPTH(BUF_DEPTH), .DDA_FRAC(DDA_FRAC)) u_dut (
    .CLK, .reset, .SCK, .CS, .COPI, .ENC_A, .ENC_B, .HALT, .CIPO,
    .PHASE_A1, .PHASE_A2, .PHASE_B1, .PHASE_B2, .VREF_A, .VREF_B,
    .BUFFER_DTR, .MOVE_DONE, .ENC_FAULT
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t make_word(input logic [7:0] code, input logic [55:0] payload);
    return {code, payload};
  endfunction

  function automatic logic [3:0] phase_pins();
    return {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2};
  endfunction

  // At most one step per tick and a fresh accumulator per move
  function automatic int model_steps(input tick_t duration, input rate_t increment,
                                     input rate_t incinc);
    rate_t acc;
    rate_t rate;
    int    steps;
    acc   = '0;
    rate  = increment;
    steps = 0;
    for (tick_t t = 0; t <= duration; t++) begin
      acc = acc + rate;
      if (acc >= STEP_ONE) begin
        steps++;
        acc = acc - STEP_ONE;
      end
      rate = rate + incinc;
    end
    return steps;
  endfunction

  function automatic logic [3:0] model_phase(input logic [31:0] pos, input msteps_t ms,
                                             input logic en);
    logic [31:0] full_step;
    full_step = pos >> ms;
    if (!en) return 4'b0000;
    case (full_step[1:0])
      2'd0:    return 4'b1010;  // A1 B1
      2'd1:    return 4'b0110;  // A2 B1
      2'd2:    return 4'b0101;  // A2 B2
      default: return 4'b1001;  // A1 B2
    endcase
  endfunction

  task automatic fail_run(input string msg);
    fail_seen = 1'b1;
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_phase(input logic [3:0] got, input logic [3:0] exp,
                             input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_level(input current_t got, input current_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // Mode 0 host that sets COPI with SCK low and reads CIPO at SCK rise
  task automatic spi_xfer(input word_t tx, output word_t rx);
    word_t r;
    CS = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      COPI = tx[i];
      repeat (4) @(negedge CLK);
      r[i] = CIPO;
      SCK  = 1'b1;
      repeat (4) @(negedge CLK);
      SCK = 1'b0;
    end
    CS = 1'b1;
    repeat (8) @(negedge CLK);
    rx = r;
  endtask

  task automatic send_move(input logic dir, input tick_t dur, input rate_t inc,
                           input rate_t incinc, input logic tracked);
    word_t rx;
    int    steps;
    while (!BUFFER_DTR) @(negedge CLK);
    spi_xfer(make_word(CMD_COORDINATED_STEP, {55'd0, dir}), rx);
    spi_xfer(dur, rx);
    spi_xfer(inc, rx);
    if (tracked) begin
      steps = model_steps(dur, inc, incinc);
      expect_q.push_back(dir ? steps : -steps);
    end
    spi_xfer(incinc, rx);  // Reply is the snapshot taken at the header
    check_count(count_t'(rx), enc_model, "encoder snapshot");
  endtask

  // Gray sequence 00 10 11 01 with A leading B going forward
  task automatic enc_edges(input int n, input logic fwd);
    for (int k = 0; k < n; k++) begin
      enc_phase = fwd ? enc_phase + 2'd1 : enc_phase - 2'd1;
      ENC_A     = enc_phase[0] ^ enc_phase[1];
      ENC_B     = enc_phase[1];
      enc_model = fwd ? enc_model + 1 : enc_model - 1;
      repeat (4) @(negedge CLK);
    end
  endtask

  task automatic measure_duty(output int high_a, output int high_b);
    high_a = 0;
    high_b = 0;
    repeat (256) begin
      @(negedge CLK);
      if (VREF_A) high_a++;
      if (VREF_B) high_b++;
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    forever begin
      @(posedge CLK);
      cycles++;
      if (cycles > cycle_limit)
        fail_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin : compare_moves
    int delta;
    wait (reset_done);
    forever begin
      @(MOVE_DONE);
      if (expect_q.size() == 0) begin
        fail_run("MOVE_DONE toggled while no move was outstanding");
      end else begin
        delta   = expect_q.pop_front();
        net_pos = net_pos + 32'(delta);
        @(posedge CLK);  // Last step lands in the position counter here
        @(negedge CLK);
        check_phase(phase_pins(), model_phase(net_pos, cur_msteps, 1'b1),
                    "phases after move");
      end
    end
  end

  initial begin : stimulus
    word_t       rx;
    int          duty_a;
    int          duty_b;
    int          lo_duty;
    int          wait_cnt;
    longint      ticks;
    longint      words;
    logic [31:0] r;
    logic        done_before;
    SCK   = 1'b0;
    CS    = 1'b1;
    COPI  = 1'b0;
    ENC_A = 1'b0;
    ENC_B = 1'b0;
    HALT  = 1'b0;
    reset = 1'b1;

    ticks = 0;
    for (int m = 0; m < NUM_MOVES; m++) begin
      r            = lcg_next();
      mv_dur[m]    = tick_t'(20 + r % 60);
      mv_dir[m]    = r[16];
      mv_inc[m]    = rate_t'({1'b0, lcg_next(), 31'd0} >> (63 - DDA_FRAC));
      mv_incinc[m] = rate_t'({lcg_next(), 32'd0}) >>> (70 - DDA_FRAC);
      ticks += mv_dur[m] + 1;
    end
    ticks += (LONG_DUR + 1) * (BUF_DEPTH + 1);
    words = 2 + 6 + 4 * (NUM_MOVES + BUF_DEPTH + 1);
    cycle_limit = 2 * int'(ticks * (DIVISOR + 1) + words * WORD_CYCLES + 4000);

    repeat (4) @(negedge CLK);
    reset      = 1'b0;
    reset_done = 1'b1;
    check_bit(MOVE_DONE, 1'b0, "MOVE_DONE after reset");
    check_bit(BUFFER_DTR, 1'b1, "BUFFER_DTR after reset");
    check_bit(CIPO, 1'b0, "CIPO after reset");
    check_phase(phase_pins(), 4'b0000, "phases after reset");

    spi_xfer(make_word(CMD_API_VERSION, 56'd0), rx);
    spi_xfer(64'd0, rx);
    check_word(rx, {40'd0, 8'd1, 8'd2, 8'd3}, "API version");

    spi_xfer(make_word(CMD_CLK_DIVISOR, 56'(DIVISOR)), rx);
    cur_msteps = 3'd2;
    spi_xfer(make_word(CMD_MOTORCONFIG, {40'd0, 8'd40, 5'd0, cur_msteps}), rx);
    measure_duty(duty_a, duty_b);
    check_level(current_t'(duty_a), 8'd40, "VREF_A high cycles");
    check_level(current_t'(duty_b), 8'd40, "VREF_B high cycles");
    lo_duty = duty_a;
    spi_xfer(make_word(CMD_MOTORCONFIG, {40'd0, 8'd200, 5'd0, cur_msteps}), rx);
    measure_duty(duty_a, duty_b);
    check_level(current_t'(duty_a), 8'd200, "VREF_A high cycles");
    check_level(current_t'(duty_b), 8'd200, "VREF_B high cycles");
    check_bit(duty_a > lo_duty, 1'b1, "duty rise with current");

    spi_xfer(make_word(CMD_MOTOR_ENABLE, 56'd1), rx);
    check_phase(phase_pins(), model_phase(net_pos, cur_msteps, 1'b1), "phases enabled");
    spi_xfer(make_word(CMD_MOTOR_ENABLE, 56'd0), rx);
    check_phase(phase_pins(), model_phase(net_pos, cur_msteps, 1'b0), "phases disabled");
    spi_xfer(make_word(CMD_MOTOR_ENABLE, 56'd1), rx);

    enc_edges(37, 1'b1);
    enc_edges(5, 1'b0);

    for (int m = 0; m < NUM_MOVES; m++)
      send_move(mv_dir[m], mv_dur[m], mv_inc[m], mv_incinc[m], 1'b1);
    while (expect_q.size() != 0) @(negedge CLK);
    repeat (2) @(negedge CLK);

    check_bit(ENC_FAULT, 1'b0, "ENC_FAULT after clean quadrature edges");
    ENC_A = ~ENC_A;  // Both lines at once
    ENC_B = ~ENC_B;
    wait_cnt = 0;
    while (!ENC_FAULT && wait_cnt < 20) begin
      @(negedge CLK);
      wait_cnt++;
    end
    check_bit(ENC_FAULT, 1'b1, "ENC_FAULT after simultaneous edges");

    // Stepper holds the first long move and the rest fill the buffer
    for (int k = 0; k <= BUF_DEPTH; k++)
      send_move(1'b1, tick_t'(LONG_DUR), STEP_ONE / 2, '0, 1'b0);
    wait_cnt = 0;
    while (BUFFER_DTR && wait_cnt < 20) begin
      @(negedge CLK);
      wait_cnt++;
    end
    check_bit(BUFFER_DTR, 1'b0, "BUFFER_DTR with full buffer");

    done_before = MOVE_DONE;
    @(negedge CLK);
    HALT = 1'b1;
    @(negedge CLK);
    HALT = 1'b0;
    wait_cnt = 0;
    while (!BUFFER_DTR && wait_cnt < 20) begin
      @(negedge CLK);
      wait_cnt++;
    end
    check_bit(BUFFER_DTR, 1'b1, "BUFFER_DTR after halt");
    // Longer than the halted move would still have run
    repeat ((LONG_DUR + 1) * (DIVISOR + 1) + 100) @(negedge CLK);
    check_bit(MOVE_DONE, done_before, "MOVE_DONE after halt");

    if (!fail_seen) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- files.f
src/motion_pkg.sv
src/move_if.sv
src/spi_word.sv
src/cmd_decoder.sv
src/move_buffer.sv
src/dda_stepper.sv
src/hbridge_driver.sv
src/quad_enc.sv
src/motion_top.sv
verif/tb_motion_top.sv

//--- Bender.yml
package:
  name: motion_axis

sources:
  - files:
      - src/motion_pkg.sv
      - src/move_if.sv
      - src/spi_word.sv
      - src/cmd_decoder.sv
      - src/move_buffer.sv
      - src/dda_stepper.sv
      - src/hbridge_driver.sv
      - src/quad_enc.sv
      - src/motion_top.sv
  - target: test
    files:
      - verif/tb_motion_top.sv
